//--- hw/id_pkg.sv
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int ALU_OP_W = 12;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // one-hot bit positions of alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [4:0] REG_RA = 5'd31; // jal link register

    // same word seen as r, i or j format
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] index;
        } j;
    } inst_t;

endpackage

`default_nettype wire

//--- hw/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
    id_pkg::alu_op_t   alu_op;
    logic              src1_is_sa;
    logic              src1_is_pc;
    logic              src2_is_imm;
    logic              src2_ext0;
    logic              src2_is_8;
    logic              gr_we;
    logic              mem_we;
    logic              load_op;
    id_pkg::reg_addr_t dest;
    logic              rs_used;
    logic              rt_used;
    logic              is_beq;
    logic              is_bne;
    logic              is_j;     // j or jal
    logic              is_jr;

    modport dec (output alu_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_ext0, src2_is_8,
                 gr_we, mem_we, load_op, dest, rs_used, rt_used,
                 is_beq, is_bne, is_j, is_jr);
    modport user (input alu_op, src1_is_sa, src1_is_pc, src2_is_imm, src2_ext0, src2_is_8,
                  gr_we, mem_we, load_op, dest, rs_used, rt_used,
                  is_beq, is_bne, is_j, is_jr);
endinterface

`default_nettype wire

//--- hw/bypass_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bypass_if;
    id_pkg::reg_addr_t es_dest;
    id_pkg::word_t     es_result;
    logic              es_load;   // es result not ready yet
    id_pkg::reg_addr_t ms_dest;
    id_pkg::word_t     ms_result;
    logic              ws_we;
    id_pkg::reg_addr_t ws_dest;
    id_pkg::word_t     ws_wdata;

    modport src (output es_dest, es_result, es_load,
                 ms_dest, ms_result,
                 ws_we, ws_dest, ws_wdata);
    modport fwd (input es_dest, es_result, es_load,
                 ms_dest, ms_result,
                 ws_we, ws_dest, ws_wdata);
endinterface

`default_nettype wire

//--- hw/id_latch.sv
`timescale 1ns/1ps
`default_nettype none

module id_latch (
    input  logic          clk,
    input  logic          reset,
    input  logic          fs_valid,
    input  id_pkg::inst_t fs_inst,
    input  id_pkg::word_t fs_pc,
    input  logic          es_allowin,
    input  logic          stall,
    output logic          ds_allowin,
    output logic          ready_go,
    output id_pkg::inst_t ds_inst,
    output id_pkg::word_t ds_pc
);

    logic ds_valid;

    assign ready_go   = ds_valid && !stall;
    assign ds_allowin = !ds_valid || (ready_go && es_allowin); // empty or leaving

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

endmodule

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  id_pkg::inst_t ds_inst,
    decode_if.dec         dec
);

    logic            special;
    logic            inst_addu, inst_subu, inst_slt, inst_sltu;
    logic            inst_and, inst_or, inst_xor, inst_nor;
    logic            inst_sll, inst_srl, inst_sra, inst_jr;
    logic            inst_addiu, inst_slti, inst_sltiu, inst_andi;
    logic            inst_ori, inst_xori, inst_lui;
    logic            inst_lw, inst_sw;
    logic            inst_beq, inst_bne, inst_j, inst_jal;
    logic            r_alu;
    logic            shift_sa;
    logic            i_alu;
    logic            gr_we;
    id_pkg::alu_op_t alu_op;

    assign special = ds_inst.r.op == id_pkg::OP_SPECIAL;

    assign inst_addu  = special && ds_inst.r.func == id_pkg::FN_ADDU;
    assign inst_subu  = special && ds_inst.r.func == id_pkg::FN_SUBU;
    assign inst_slt   = special && ds_inst.r.func == id_pkg::FN_SLT;
    assign inst_sltu  = special && ds_inst.r.func == id_pkg::FN_SLTU;
    assign inst_and   = special && ds_inst.r.func == id_pkg::FN_AND;
    assign inst_or    = special && ds_inst.r.func == id_pkg::FN_OR;
    assign inst_xor   = special && ds_inst.r.func == id_pkg::FN_XOR;
    assign inst_nor   = special && ds_inst.r.func == id_pkg::FN_NOR;
    assign inst_sll   = special && ds_inst.r.func == id_pkg::FN_SLL;
    assign inst_srl   = special && ds_inst.r.func == id_pkg::FN_SRL;
    assign inst_sra   = special && ds_inst.r.func == id_pkg::FN_SRA;
    assign inst_jr    = special && ds_inst.r.func == id_pkg::FN_JR;

    assign inst_addiu = ds_inst.i.op == id_pkg::OP_ADDIU;
    assign inst_slti  = ds_inst.i.op == id_pkg::OP_SLTI;
    assign inst_sltiu = ds_inst.i.op == id_pkg::OP_SLTIU;
    assign inst_andi  = ds_inst.i.op == id_pkg::OP_ANDI;
    assign inst_ori   = ds_inst.i.op == id_pkg::OP_ORI;
    assign inst_xori  = ds_inst.i.op == id_pkg::OP_XORI;
    assign inst_lui   = ds_inst.i.op == id_pkg::OP_LUI;
    assign inst_lw    = ds_inst.i.op == id_pkg::OP_LW;
    assign inst_sw    = ds_inst.i.op == id_pkg::OP_SW;
    assign inst_beq   = ds_inst.i.op == id_pkg::OP_BEQ;
    assign inst_bne   = ds_inst.i.op == id_pkg::OP_BNE;
    assign inst_j     = ds_inst.j.op == id_pkg::OP_J;
    assign inst_jal   = ds_inst.j.op == id_pkg::OP_JAL;

    assign shift_sa = inst_sll | inst_srl | inst_sra;
    assign r_alu    = inst_addu | inst_subu | inst_slt | inst_sltu
                    | inst_and | inst_or | inst_xor | inst_nor | shift_sa;
    assign i_alu    = inst_addiu | inst_slti | inst_sltiu | inst_andi
                    | inst_ori | inst_xori | inst_lui;

    assign alu_op[id_pkg::ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
    assign alu_op[id_pkg::ALU_SUB]  = inst_subu;
    assign alu_op[id_pkg::ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[id_pkg::ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[id_pkg::ALU_AND]  = inst_and | inst_andi;
    assign alu_op[id_pkg::ALU_NOR]  = inst_nor;
    assign alu_op[id_pkg::ALU_OR]   = inst_or | inst_ori;
    assign alu_op[id_pkg::ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[id_pkg::ALU_SLL]  = inst_sll;
    assign alu_op[id_pkg::ALU_SRL]  = inst_srl;
    assign alu_op[id_pkg::ALU_SRA]  = inst_sra;
    assign alu_op[id_pkg::ALU_LUI]  = inst_lui;

    assign gr_we = r_alu | i_alu | inst_lw | inst_jal;

    assign dec.alu_op      = alu_op;
    assign dec.src1_is_sa  = shift_sa;
    assign dec.src1_is_pc  = inst_jal;  // link value is pc + 8
    assign dec.src2_is_imm = i_alu | inst_lw | inst_sw;
    assign dec.src2_ext0   = inst_andi | inst_ori | inst_xori;
    assign dec.src2_is_8   = inst_jal;
    assign dec.gr_we       = gr_we;
    assign dec.mem_we      = inst_sw;
    assign dec.load_op     = inst_lw;

    assign dec.dest = !gr_we          ? 5'd0 :
                      inst_jal        ? id_pkg::REG_RA :
                      (i_alu | inst_lw) ? ds_inst.i.rt :
                                        ds_inst.r.rd;

    assign dec.rs_used = (r_alu & ~shift_sa) | (i_alu & ~inst_lui)
                       | inst_lw | inst_sw | inst_beq | inst_bne | inst_jr;
    assign dec.rt_used = r_alu | inst_beq | inst_bne | inst_sw;

    assign dec.is_beq = inst_beq;
    assign dec.is_bne = inst_bne;
    assign dec.is_j   = inst_j | inst_jal;
    assign dec.is_jr  = inst_jr;

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    bypass_if.fwd             wr
);

    id_pkg::word_t mem [32];

    always_ff @(posedge clk) begin
        if (wr.ws_we && wr.ws_dest != 5'd0) begin
            mem[wr.ws_dest] <= wr.ws_wdata;
        end
    end

    // $0 is hardwired
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : mem[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : mem[raddr2];

endmodule

`default_nettype wire

//--- hw/operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
    input  id_pkg::inst_t ds_inst,
    decode_if.user        dec,
    bypass_if.fwd         byp,
    input  id_pkg::word_t rdata1,
    input  id_pkg::word_t rdata2,
    output id_pkg::word_t rs_value,
    output id_pkg::word_t rt_value,
    output logic          stall
);

    logic rs_chk, rt_chk;
    logic rs_es, rs_ms, rs_ws;
    logic rt_es, rt_ms, rt_ws;

    assign rs_chk = dec.rs_used && ds_inst.r.rs != 5'd0;
    assign rt_chk = dec.rt_used && ds_inst.r.rt != 5'd0;

    assign rs_es = rs_chk && ds_inst.r.rs == byp.es_dest;
    assign rs_ms = rs_chk && ds_inst.r.rs == byp.ms_dest;
    assign rs_ws = rs_chk && byp.ws_we && ds_inst.r.rs == byp.ws_dest;

    assign rt_es = rt_chk && ds_inst.r.rt == byp.es_dest;
    assign rt_ms = rt_chk && ds_inst.r.rt == byp.ms_dest;
    assign rt_ws = rt_chk && byp.ws_we && ds_inst.r.rt == byp.ws_dest;

    // youngest producer wins
    assign rs_value = rs_es ? byp.es_result :
                      rs_ms ? byp.ms_result :
                      rs_ws ? byp.ws_wdata  :
                              rdata1;

    assign rt_value = rt_es ? byp.es_result :
                      rt_ms ? byp.ms_result :
                      rt_ws ? byp.ws_wdata  :
                              rdata2;

    // load in es has no data yet
    assign stall = byp.es_load && (rs_es || rt_es);

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  id_pkg::inst_t ds_inst,
    input  id_pkg::word_t ds_pc,
    input  logic          ready_go,
    decode_if.user        dec,
    input  id_pkg::word_t rs_value,
    input  id_pkg::word_t rt_value,
    output logic          br_taken,
    output id_pkg::word_t br_target
);

    id_pkg::word_t pc_plus4;
    id_pkg::word_t br_offset;
    logic          rs_eq_rt;

    assign pc_plus4  = ds_pc + 32'd4;
    assign br_offset = {{14{ds_inst.i.imm[15]}}, ds_inst.i.imm, 2'b00};
    assign rs_eq_rt  = rs_value == rt_value;

    assign br_taken = ready_go && ((dec.is_beq && rs_eq_rt)
                                || (dec.is_bne && !rs_eq_rt)
                                || dec.is_j
                                || dec.is_jr);

    assign br_target = (dec.is_beq || dec.is_bne) ? pc_plus4 + br_offset :
                       dec.is_jr                  ? rs_value :
                       {pc_plus4[31:28], ds_inst.j.index, 2'b00}; // j and jal region jump

endmodule

`default_nettype wire

//--- hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              fs_valid,
    input  id_pkg::inst_t     fs_inst,
    input  id_pkg::word_t     fs_pc,
    output logic              ds_allowin,
    input  logic              es_allowin,
    output logic              ds_to_es_valid,
    output id_pkg::alu_op_t   alu_op,
    output logic              src1_is_sa,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              src2_ext0,
    output logic              src2_is_8,
    output logic              gr_we,
    output logic              mem_we,
    output logic              load_op,
    output id_pkg::reg_addr_t dest,
    output logic [15:0]       imm,
    output id_pkg::word_t     rs_value,
    output id_pkg::word_t     rt_value,
    output id_pkg::word_t     ds_pc,
    output logic              br_taken,
    output id_pkg::word_t     br_target,
    input  id_pkg::reg_addr_t es_dest,
    input  id_pkg::word_t     es_result,
    input  logic              es_load,
    input  id_pkg::reg_addr_t ms_dest,
    input  id_pkg::word_t     ms_result,
    input  logic              ws_we,
    input  id_pkg::reg_addr_t ws_dest,
    input  id_pkg::word_t     ws_wdata
);

    id_pkg::inst_t ds_inst;
    id_pkg::word_t rf_rdata1, rf_rdata2;
    logic          ready_go;
    logic          stall;

    decode_if dec_bus ();
    bypass_if byp_bus ();

    assign byp_bus.es_dest   = es_dest;
    assign byp_bus.es_result = es_result;
    assign byp_bus.es_load   = es_load;
    assign byp_bus.ms_dest   = ms_dest;
    assign byp_bus.ms_result = ms_result;
    assign byp_bus.ws_we     = ws_we;
    assign byp_bus.ws_dest   = ws_dest;
    assign byp_bus.ws_wdata  = ws_wdata;

    id_latch u_latch (
        .clk        (clk),
        .reset      (reset),
        .fs_valid   (fs_valid),
        .fs_inst    (fs_inst),
        .fs_pc      (fs_pc),
        .es_allowin (es_allowin),
        .stall      (stall),
        .ds_allowin (ds_allowin),
        .ready_go   (ready_go),
        .ds_inst    (ds_inst),
        .ds_pc      (ds_pc)
    );

    inst_decoder u_dec (
        .ds_inst (ds_inst),
        .dec     (dec_bus)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (ds_inst.r.rs),
        .raddr2 (ds_inst.r.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (byp_bus)
    );

    operand_fwd u_fwd (
        .ds_inst  (ds_inst),
        .dec      (dec_bus),
        .byp      (byp_bus),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .stall    (stall)
    );

    branch_unit u_br (
        .ds_inst   (ds_inst),
        .ds_pc     (ds_pc),
        .ready_go  (ready_go),
        .dec       (dec_bus),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    assign ds_to_es_valid = ready_go;

    assign alu_op      = dec_bus.alu_op;
    assign src1_is_sa  = dec_bus.src1_is_sa;
    assign src1_is_pc  = dec_bus.src1_is_pc;
    assign src2_is_imm = dec_bus.src2_is_imm;
    assign src2_ext0   = dec_bus.src2_ext0;
    assign src2_is_8   = dec_bus.src2_is_8;
    assign gr_we       = dec_bus.gr_we;
    assign mem_we      = dec_bus.mem_we;
    assign load_op     = dec_bus.load_op;
    assign dest        = dec_bus.dest;
    assign imm         = ds_inst.i.imm;  // extension done in execute

endmodule

`default_nettype wire

//--- tests/id_model.svh
// expected decode controls, one field per decode_if signal
typedef struct packed {
    id_pkg::alu_op_t   alu_op;
    logic              src1_is_sa;
    logic              src1_is_pc;
    logic              src2_is_imm;
    logic              src2_ext0;
    logic              src2_is_8;
    logic              gr_we;
    logic              mem_we;
    logic              load_op;
    id_pkg::reg_addr_t dest;
    logic              rs_used;
    logic              rt_used;
    logic              is_beq;
    logic              is_bne;
    logic              is_j;
    logic              is_jr;
} ctrl_t;

typedef struct packed {
    id_pkg::reg_addr_t es_dest;
    id_pkg::word_t     es_result;
    logic              es_load;
    id_pkg::reg_addr_t ms_dest;
    id_pkg::word_t     ms_result;
    logic              ws_we;
    id_pkg::reg_addr_t ws_dest;
    id_pkg::word_t     ws_wdata;
} byp_t;

typedef struct packed {
    id_pkg::inst_t inst;
    id_pkg::word_t pc;
} held_t;

id_pkg::word_t rf_model [32];  // mirror of the register file
held_t         model_q [$];    // accepted, not yet issued

function automatic ctrl_t decode_ref(input id_pkg::inst_t inst);
    ctrl_t c;
    int    op_bit;
    logic  special;
    logic  jal;
    logic  r_alu;
    logic  i_alu;
    logic  shift;
    c       = '0;
    op_bit  = -1;
    special = inst.r.op == id_pkg::OP_SPECIAL;
    if (special) begin
        case (inst.r.func)
            id_pkg::FN_ADDU: op_bit = id_pkg::ALU_ADD;
            id_pkg::FN_SUBU: op_bit = id_pkg::ALU_SUB;
            id_pkg::FN_SLT:  op_bit = id_pkg::ALU_SLT;
            id_pkg::FN_SLTU: op_bit = id_pkg::ALU_SLTU;
            id_pkg::FN_AND:  op_bit = id_pkg::ALU_AND;
            id_pkg::FN_OR:   op_bit = id_pkg::ALU_OR;
            id_pkg::FN_XOR:  op_bit = id_pkg::ALU_XOR;
            id_pkg::FN_NOR:  op_bit = id_pkg::ALU_NOR;
            id_pkg::FN_SLL:  op_bit = id_pkg::ALU_SLL;
            id_pkg::FN_SRL:  op_bit = id_pkg::ALU_SRL;
            id_pkg::FN_SRA:  op_bit = id_pkg::ALU_SRA;
            id_pkg::FN_JR:   c.is_jr = 1'b1;
            default:         op_bit = -1;
        endcase
    end else begin
        case (inst.i.op)
            id_pkg::OP_ADDIU: op_bit = id_pkg::ALU_ADD;
            id_pkg::OP_SLTI:  op_bit = id_pkg::ALU_SLT;
            id_pkg::OP_SLTIU: op_bit = id_pkg::ALU_SLTU;
            id_pkg::OP_ANDI:  op_bit = id_pkg::ALU_AND;
            id_pkg::OP_ORI:   op_bit = id_pkg::ALU_OR;
            id_pkg::OP_XORI:  op_bit = id_pkg::ALU_XOR;
            id_pkg::OP_LUI:   op_bit = id_pkg::ALU_LUI;
            id_pkg::OP_LW:    c.load_op = 1'b1;
            id_pkg::OP_SW:    c.mem_we = 1'b1;
            id_pkg::OP_BEQ:   c.is_beq = 1'b1;
            id_pkg::OP_BNE:   c.is_bne = 1'b1;
            id_pkg::OP_J:     c.is_j = 1'b1;
            id_pkg::OP_JAL:   c.is_j = 1'b1;
            default:          op_bit = -1;
        endcase
    end
    jal   = inst.j.op == id_pkg::OP_JAL;
    r_alu = special && op_bit >= 0;
    i_alu = !special && op_bit >= 0;
    shift = r_alu && (inst.r.func inside {id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA});
    if (c.load_op || c.mem_we || jal) begin
        op_bit = id_pkg::ALU_ADD;  // address or link add
    end
    if (op_bit >= 0) begin
        c.alu_op[op_bit] = 1'b1;
    end
    c.src1_is_sa  = shift;
    c.src1_is_pc  = jal;
    c.src2_is_8   = jal;
    c.src2_is_imm = i_alu || c.load_op || c.mem_we;
    c.src2_ext0   = !special && (inst.i.op inside {id_pkg::OP_ANDI, id_pkg::OP_ORI,
                                                   id_pkg::OP_XORI});
    c.gr_we       = r_alu || i_alu || c.load_op || jal;
    if (!c.gr_we) begin
        c.dest = '0;
    end else if (jal) begin
        c.dest = id_pkg::REG_RA;
    end else if (i_alu || c.load_op) begin
        c.dest = inst.i.rt;
    end else begin
        c.dest = inst.r.rd;
    end
    c.rs_used = (r_alu && !shift) || (i_alu && inst.i.op != id_pkg::OP_LUI) || c.load_op
              || c.mem_we || c.is_beq || c.is_bne || c.is_jr;
    c.rt_used = r_alu || c.is_beq || c.is_bne || c.mem_we;
    return c;
endfunction

function automatic id_pkg::word_t operand_ref(input id_pkg::reg_addr_t r, input logic used,
                                              input byp_t b);
    if (used && r != 5'd0) begin
        if (r == b.es_dest) return b.es_result;
        if (r == b.ms_dest) return b.ms_result;
        if (b.ws_we && r == b.ws_dest) return b.ws_wdata;
    end
    return rf_model[r];
endfunction

function automatic logic load_use_ref(input id_pkg::inst_t inst, input ctrl_t c, input byp_t b);
    logic rs_hit;
    logic rt_hit;
    rs_hit = c.rs_used && inst.r.rs != 5'd0 && inst.r.rs == b.es_dest;
    rt_hit = c.rt_used && inst.r.rt != 5'd0 && inst.r.rt == b.es_dest;
    return b.es_load && (rs_hit || rt_hit);
endfunction

function automatic logic branch_taken_ref(input ctrl_t c, input id_pkg::word_t rs,
                                          input id_pkg::word_t rt);
    return (c.is_beq && rs == rt) || (c.is_bne && rs != rt) || c.is_j || c.is_jr;
endfunction

function automatic id_pkg::word_t branch_target_ref(input id_pkg::inst_t inst,
                                                    input id_pkg::word_t pc, input ctrl_t c,
                                                    input id_pkg::word_t rs);
    id_pkg::word_t seq;
    id_pkg::word_t offset;
    seq    = pc + 32'd4;
    offset = 32'($signed(inst.i.imm));
    if (c.is_beq || c.is_bne) return seq + (offset << 2);
    if (c.is_jr) return rs;
    return {seq[31:28], inst.j.index, 2'b00};
endfunction

//--- tests/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    `include "id_model.svh"

    logic              clk;
    logic              reset;
    logic              fs_valid;
    id_pkg::inst_t     fs_inst;
    id_pkg::word_t     fs_pc;
    logic              es_allowin;
    byp_t              byp;
    logic              ds_allowin;
    logic              ds_to_es_valid;
    id_pkg::alu_op_t   alu_op;
    logic              src1_is_sa, src1_is_pc, src2_is_imm, src2_ext0, src2_is_8;
    logic              gr_we, mem_we, load_op;
    id_pkg::reg_addr_t dest;
    logic [15:0]       imm;
    id_pkg::word_t     rs_value, rt_value, ds_pc;
    logic              br_taken;
    id_pkg::word_t     br_target;

    localparam logic [5:0] FN_TBL [13] = '{id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA,
        id_pkg::FN_JR, id_pkg::FN_ADDU, id_pkg::FN_SUBU, id_pkg::FN_AND, id_pkg::FN_OR,
        id_pkg::FN_XOR, id_pkg::FN_NOR, id_pkg::FN_SLT, id_pkg::FN_SLTU, 6'h18};
    localparam logic [5:0] OP_TBL [13] = '{id_pkg::OP_J, id_pkg::OP_JAL, id_pkg::OP_BEQ,
        id_pkg::OP_BNE, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU, id_pkg::OP_ANDI,
        id_pkg::OP_ORI, id_pkg::OP_XORI, id_pkg::OP_LUI, id_pkg::OP_LW, id_pkg::OP_SW};

    string         test_name;
    int            test_errors, total_errors, tests_run, tests_failed;
    int            issued, stalls;
    id_pkg::word_t next_pc;

    id_stage dut_i (
        .clk (clk), .reset (reset),
        .fs_valid (fs_valid), .fs_inst (fs_inst), .fs_pc (fs_pc),
        .ds_allowin (ds_allowin), .es_allowin (es_allowin), .ds_to_es_valid (ds_to_es_valid),
        .alu_op (alu_op), .src1_is_sa (src1_is_sa), .src1_is_pc (src1_is_pc),
        .src2_is_imm (src2_is_imm), .src2_ext0 (src2_ext0), .src2_is_8 (src2_is_8),
        .gr_we (gr_we), .mem_we (mem_we), .load_op (load_op), .dest (dest), .imm (imm),
        .rs_value (rs_value), .rt_value (rt_value), .ds_pc (ds_pc),
        .br_taken (br_taken), .br_target (br_target),
        .es_dest (byp.es_dest), .es_result (byp.es_result), .es_load (byp.es_load),
        .ms_dest (byp.ms_dest), .ms_result (byp.ms_result),
        .ws_we (byp.ws_we), .ws_dest (byp.ws_dest), .ws_wdata (byp.ws_wdata)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic compare_word(input string what, input id_pkg::word_t exp,
                                input id_pkg::word_t act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_reg_addr(input string what, input id_pkg::reg_addr_t exp,
                                    input id_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %0d actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_alu_op(input string what, input id_pkg::alu_op_t exp,
                                  input id_pkg::alu_op_t act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    function automatic logic chance(input int pct);
        return int'($urandom_range(0, 99)) < pct;
    endfunction

    function automatic id_pkg::reg_addr_t rand_reg();
        if ($urandom_range(0, 3) == 0) return id_pkg::reg_addr_t'($urandom_range(0, 31));
        return id_pkg::reg_addr_t'($urandom_range(0, 7));  // crowd a few regs for hazards
    endfunction

    function automatic id_pkg::inst_t random_inst();
        id_pkg::inst_t inst;
        int            pick;
        inst      = $urandom;
        inst.r.rs = rand_reg();
        inst.r.rt = rand_reg();
        inst.r.rd = rand_reg();
        pick      = int'($urandom_range(0, 19));
        if (pick < 8) begin
            inst.r.op   = id_pkg::OP_SPECIAL;
            inst.r.func = FN_TBL[$urandom_range(0, 12)];
        end else if (pick < 19) begin
            inst.r.op = OP_TBL[$urandom_range(0, 12)];
        end else begin
            inst.r.op = ($urandom_range(0, 1) != 0) ? 6'h20 : 6'h3f;  // not decoded
        end
        return inst;
    endfunction

    task automatic drive_random(input int p_fs, input int p_allow, input int p_load);
        fs_valid      = chance(p_fs);
        fs_inst       = random_inst();
        fs_pc         = next_pc;
        es_allowin    = chance(p_allow);
        byp.es_dest   = rand_reg();
        byp.es_result = $urandom;
        byp.es_load   = chance(p_load);
        byp.ms_dest   = rand_reg();
        byp.ms_result = $urandom;
        byp.ws_we     = chance(50);
        byp.ws_dest   = rand_reg();
        byp.ws_wdata  = $urandom;
    endtask

    // compare against the model, then advance it to the coming edge
    task automatic check_and_step();
        id_pkg::inst_t inst;
        ctrl_t         c;
        id_pkg::word_t exp_rs, exp_rt;
        logic          held, exp_stall, exp_valid, exp_allowin;
        held      = model_q.size() != 0;
        exp_stall = 1'b0;
        inst      = '0;
        c         = '0;
        exp_rs    = '0;
        exp_rt    = '0;
        if (held) begin
            inst      = model_q[0].inst;
            c         = decode_ref(inst);
            exp_rs    = operand_ref(inst.r.rs, c.rs_used, byp);
            exp_rt    = operand_ref(inst.r.rt, c.rt_used, byp);
            exp_stall = load_use_ref(inst, c, byp);
        end
        if (exp_stall) stalls++;
        exp_valid   = held && !exp_stall;
        exp_allowin = !held || (exp_valid && es_allowin);
        compare_bit("ds_to_es_valid", exp_valid, ds_to_es_valid);
        compare_bit("ds_allowin", exp_allowin, ds_allowin);
        if (exp_valid) begin
            compare_word("ds_pc", model_q[0].pc, ds_pc);
            compare_alu_op("alu_op", c.alu_op, alu_op);
            compare_bit("src1_is_sa", c.src1_is_sa, src1_is_sa);
            compare_bit("src1_is_pc", c.src1_is_pc, src1_is_pc);
            compare_bit("src2_is_imm", c.src2_is_imm, src2_is_imm);
            compare_bit("src2_ext0", c.src2_ext0, src2_ext0);
            compare_bit("src2_is_8", c.src2_is_8, src2_is_8);
            compare_bit("gr_we", c.gr_we, gr_we);
            compare_bit("mem_we", c.mem_we, mem_we);
            compare_bit("load_op", c.load_op, load_op);
            compare_reg_addr("dest", c.dest, dest);
            compare_word("imm", {16'd0, inst.i.imm}, {16'd0, imm});
            compare_word("rs_value", exp_rs, rs_value);
            compare_word("rt_value", exp_rt, rt_value);
            compare_bit("br_taken", branch_taken_ref(c, exp_rs, exp_rt), br_taken);
            if (c.is_beq || c.is_bne || c.is_j || c.is_jr) begin
                compare_word("br_target", branch_target_ref(inst, model_q[0].pc, c, exp_rs),
                             br_target);
            end
        end else begin
            compare_bit("br_taken", 1'b0, br_taken);
        end
        if (exp_valid && es_allowin) begin
            void'(model_q.pop_front());
            issued++;
        end
        if (fs_valid && exp_allowin) begin
            model_q.push_back('{inst: fs_inst, pc: fs_pc});
            next_pc = next_pc + 32'd4;
        end
        if (byp.ws_we && byp.ws_dest != 5'd0) rf_model[byp.ws_dest] = byp.ws_wdata;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        issued      = 0;
        stalls      = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_errors += test_errors;
        $display("test %-14s %s  issued %0d  stall cycles %0d", test_name,
                 (test_errors == 0) ? "ok" : "FAILED", issued, stalls);
    endtask

    task automatic drain_stage();
        int guard;
        guard = 0;
        while (model_q.size() != 0 && guard < 20) begin
            @(posedge clk);
            #1;
            fs_valid    = 1'b0;
            es_allowin  = 1'b1;
            byp.es_load = 1'b0;
            @(negedge clk);
            check_and_step();
            guard++;
        end
        if (model_q.size() != 0) begin
            $display("%s: the stage still held an instruction after %0d cycles", test_name,
                     guard);
            test_errors++;
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int p_fs,
                            input int p_allow, input int p_load);
        start_test(name);
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
            #1;
            drive_random(p_fs, p_allow, p_load);
            @(negedge clk);
            check_and_step();
        end
        drain_stage();
        if (issued == 0) begin
            $display("%s: no instruction was issued", test_name);
            test_errors++;
        end
        if (p_load > 0 && stalls == 0) begin
            $display("%s: no load-use stall came up", test_name);
            test_errors++;
        end
        end_test();
    endtask

    initial begin
        void'($urandom(32'h427b1c58));
        reset        = 1'b1;
        fs_valid     = 1'b0;
        fs_inst      = '0;
        fs_pc        = '0;
        es_allowin   = 1'b0;
        byp          = '0;
        next_pc      = 32'hbfc0_0000;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) rf_model[r] = '0;

        start_test("reset");
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            if (i == 2) reset = 1'b0;
            @(negedge clk);
            compare_bit("ds_to_es_valid", 1'b0, ds_to_es_valid);
            compare_bit("br_taken", 1'b0, br_taken);
            compare_bit("ds_allowin", 1'b1, ds_allowin);
        end
        end_test();

        start_test("regfile_init");
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            #1;
            byp.ws_we    = 1'b1;
            byp.ws_dest  = id_pkg::reg_addr_t'(r);
            byp.ws_wdata = $urandom;
            @(negedge clk);
            check_and_step();
        end
        end_test();

        run_test("decode_fwd", 400, 80, 100, 0);
        run_test("load_use", 400, 80, 100, 40);
        run_test("backpressure", 400, 70, 50, 20);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+tests
hw/id_pkg.sv
hw/decode_if.sv
hw/bypass_if.sv
hw/id_latch.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_fwd.sv
hw/branch_unit.sv
hw/id_stage.sv
tests/tb_id_stage.sv
